// ==== source/displayPkg.sv ====
package displayPkg;

	// 160x120 frame, one bit per colour channel
	localparam int ScreenWidth = 160;
	localparam int ScreenHeight = 120;

	typedef logic [7:0] xCoord;
	typedef logic [6:0] yCoord;
	typedef logic [2:0] colour;  // R, G, B

	localparam colour ColourBlack = 3'b000;
	localparam colour ColourWhite = 3'b111;
	localparam colour ColourGreen = 3'b010;

	// Lane dividers, one pixel wide
	localparam xCoord BorderX0 = 8'd40;
	localparam xCoord BorderX1 = 8'd80;
	localparam xCoord BorderX2 = 8'd120;

	// One write to the frame buffer
	typedef struct packed {
		xCoord x;
		yCoord y;
		colour rgb;
	} pixelWrite;

endpackage

// ==== source/tilePkg.sv ====
package tilePkg;

	localparam int TileWidth = 36;
	localparam int TileHeight = 20;
	localparam int LaneCount = 4;

	// Left edge of the tile in each lane
	localparam displayPkg::xCoord LaneX [LaneCount] = '{8'd4, 8'd43, 8'd82, 8'd121};

	// Top of the tile has passed the last screen row
	localparam int DepthEnd = 140;

	localparam int TickCycles = 4000;  // Clocks per animation step

	typedef logic [1:0] laneIndex;

	// Row just below the tile's bottom edge
	typedef logic [7:0] tileDepth;

	typedef struct packed {
		laneIndex lane;
		tileDepth depth;
	} tileState;

	// One row span for the painter
	typedef struct packed {
		displayPkg::xCoord xStart;
		displayPkg::yCoord y;
		displayPkg::colour rgb;
	} rowJob;

endpackage

// ==== source/rowPainter.sv ====
module rowPainter (
	input  logic                  CLOCK_50,
	input  logic                  reset,
	input  tilePkg::rowJob        job,
	input  logic                  jobValid,
	output logic                  jobReady,
	output displayPkg::pixelWrite paintPixel,
	output logic                  paintValid,
	input  logic                  paintReady,
	output logic                  paintDone
);
	import displayPkg::*;
	import tilePkg::*;

	rowJob      held;
	logic       busy;
	logic [5:0] offset;     // Pixel within the span
	logic       lastPixel;

	assign jobReady = !busy;
	assign paintValid = busy;
	assign paintPixel = '{held.xStart + xCoord'(offset), held.y, held.rgb};
	assign lastPixel = (offset == 6'(TileWidth - 1));

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			offset <= '0;
			paintDone <= 1'b0;
		end
		else
		begin
			paintDone <= 1'b0;
			if (jobValid && !busy)
			begin
				busy <= 1'b1;
				offset <= '0;
			end
			else if (busy && paintReady)
			begin
				if (lastPixel)
				begin
					busy <= 1'b0;
					paintDone <= 1'b1;
				end
				else
					offset <= offset + 1'b1;
			end
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (jobValid && !busy)
			held <= job;
	end

	paintHold: assert property (@(posedge CLOCK_50) disable iff (reset)
		paintValid && !paintReady |=> paintValid && $stable(paintPixel))
		else $error("Row pixel changed while stalled");

endmodule

// ==== source/screenSweeper.sv ====
module screenSweeper (
	input  logic                  CLOCK_50,
	input  logic                  reset,
	input  logic                  sweepStart,
	input  logic                  sweepBackground,
	output displayPkg::pixelWrite sweepPixel,
	output logic                  sweepValid,
	input  logic                  sweepReady,
	output logic                  sweepDone
);
	import displayPkg::*;

	xCoord x;
	yCoord y;
	logic  background;  // Bordered white rather than black
	logic  onBorder;
	logic  lastPixel;
	colour shade;

	assign onBorder = (x == BorderX0) || (x == BorderX1) || (x == BorderX2);
	assign shade = !background ? ColourBlack : (onBorder ? ColourGreen : ColourWhite);
	assign lastPixel = (x == xCoord'(ScreenWidth - 1)) && (y == yCoord'(ScreenHeight - 1));
	assign sweepPixel = '{x, y, shade};

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			x <= '0;
			y <= '0;
			background <= 1'b0;
			sweepValid <= 1'b0;
			sweepDone <= 1'b0;
		end
		else
		begin
			sweepDone <= 1'b0;
			if (sweepStart)
			begin
				x <= '0;
				y <= '0;
				background <= sweepBackground;
				sweepValid <= 1'b1;
			end
			else if (sweepValid && sweepReady)
			begin
				if (lastPixel)
				begin
					sweepValid <= 1'b0;
					sweepDone <= 1'b1;
				end
				else if (x == xCoord'(ScreenWidth - 1))  // End of line
				begin
					x <= '0;
					y <= y + 1'b1;
				end
				else
					x <= x + 1'b1;
			end
		end
	end

	sweepHold: assert property (@(posedge CLOCK_50) disable iff (reset)
		sweepValid && !sweepReady |=> sweepValid && $stable(sweepPixel))
		else $error("Sweep pixel changed while stalled");

endmodule

// ==== source/tileTracker.sv ====
module tileTracker (
	input  logic              CLOCK_50,
	input  logic              reset,
	input  logic              tileReset,
	input  logic              stepSlot,
	input  tilePkg::laneIndex stepIndex,
	output tilePkg::rowJob    drawJob,
	output logic              drawValid,
	output tilePkg::rowJob    eraseJob,
	output logic              eraseValid
);
	import displayPkg::*;
	import tilePkg::*;

	tileState tiles [LaneCount];
	tileState current;
	tileDepth nextDepth;
	tileDepth topRow;     // Row vacated by this step

	assign current = tiles[stepIndex];
	assign nextDepth = current.depth + 1'b1;
	assign topRow = current.depth - tileDepth'(TileHeight);

	always_ff @(posedge CLOCK_50)
	begin
		if (reset || tileReset)
		begin
			for (int i = 0; i < LaneCount; i++)
			begin
				tiles[i].lane <= laneIndex'(i);  // One tile per lane
				tiles[i].depth <= '0;
			end
			drawValid <= 1'b0;
			eraseValid <= 1'b0;
		end
		else if (stepSlot)
		begin
			drawValid <= current.depth < tileDepth'(ScreenHeight);
			eraseValid <= current.depth >= tileDepth'(TileHeight);
			if (nextDepth == tileDepth'(DepthEnd))
			begin
				tiles[stepIndex].depth <= '0;
				tiles[stepIndex].lane <= current.lane + 1'b1;  // Wraps after lane 3
			end
			else
				tiles[stepIndex].depth <= nextDepth;
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (stepSlot)
		begin
			drawJob <= '{LaneX[current.lane], yCoord'(current.depth), ColourBlack};
			eraseJob <= '{LaneX[current.lane], yCoord'(topRow), ColourWhite};
		end
	end

	for (genvar i = 0; i < LaneCount; i++)
	begin : gDepthCheck
		depthBound: assert property (@(posedge CLOCK_50) disable iff (reset)
			tiles[i].depth < tileDepth'(DepthEnd))
			else $error("Tile %0d went past the end depth", i);
	end

endmodule

// ==== source/tileSequencer.sv ====
module tileSequencer (
	input  logic                  CLOCK_50,
	input  logic                  reset,
	input  logic                  gameKey,     // Active low
	output displayPkg::pixelWrite pixelOut,
	output logic                  pixelValid,
	input  logic                  pixelReady,
	output logic                  sweepStart,
	output logic                  sweepBackground,
	input  displayPkg::pixelWrite sweepPixel,
	input  logic                  sweepValid,
	output logic                  sweepReady,
	input  logic                  sweepDone,
	output logic                  tileReset,
	output logic                  stepSlot,
	output tilePkg::laneIndex     stepIndex,
	input  tilePkg::rowJob        drawJob,
	input  logic                  drawValid,
	input  tilePkg::rowJob        eraseJob,
	input  logic                  eraseValid,
	output tilePkg::rowJob        job,
	output logic                  jobValid,
	input  logic                  jobReady,
	input  displayPkg::pixelWrite paintPixel,
	input  logic                  paintValid,
	output logic                  paintReady,
	input  logic                  paintDone
);
	import tilePkg::*;

	typedef enum logic [2:0] {OffIdle, Sweeping, OnIdle, Stepping, PaintDraw, PaintErase} seqState;
	typedef logic [$clog2(TickCycles)-1:0] tickCounter;

	seqState    state;
	logic       gameOn;
	logic       keyPrev;
	logic       togglePending;
	logic       tickPending;
	logic       jobIssued;     // Current row already handed to the painter
	tickCounter tickCount;
	laneIndex   slot;
	logic       isIdle;
	logic       painting;
	logic       keyFall;
	logic       applyToggle;
	logic       startStep;
	logic       countEnable;
	logic       tick;
	logic       rowValid;
	logic       rowFinished;

	assign isIdle = (state == OffIdle) || (state == OnIdle);
	assign painting = (state == PaintDraw) || (state == PaintErase);
	assign keyFall = keyPrev && !gameKey;

	// A held toggle beats a held tick
	assign applyToggle = isIdle && togglePending;
	assign startStep = (state == OnIdle) && tickPending && !togglePending;

	assign countEnable = gameOn && (state != Sweeping);
	assign tick = countEnable && (tickCount == tickCounter'(TickCycles - 1));

	assign sweepStart = applyToggle;
	assign sweepBackground = !gameOn;           // Turning on
	assign tileReset = applyToggle && !gameOn;
	assign stepSlot = (state == Stepping);
	assign stepIndex = slot;

	assign rowValid = (state == PaintErase) ? eraseValid : drawValid;
	assign rowFinished = painting && (!rowValid || paintDone);  // Empty rows are skipped
	assign job = (state == PaintErase) ? eraseJob : drawJob;
	assign jobValid = painting && rowValid && !jobIssued;

	// Only the active source sees ready
	always_comb
	begin
		pixelOut = paintPixel;
		pixelValid = 1'b0;
		if (state == Sweeping)
		begin
			pixelOut = sweepPixel;
			pixelValid = sweepValid;
		end
		else if (painting)
			pixelValid = paintValid;
	end

	assign sweepReady = (state == Sweeping) && pixelReady;
	assign paintReady = painting && pixelReady;

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			state <= OffIdle;
			gameOn <= 1'b0;
			keyPrev <= 1'b1;
			togglePending <= 1'b0;
			tickPending <= 1'b0;
			jobIssued <= 1'b0;
			tickCount <= '0;
			slot <= '0;
		end
		else
		begin
			keyPrev <= gameKey;
			if (keyFall)
				togglePending <= 1'b1;
			else if (applyToggle)
				togglePending <= 1'b0;

			if (!countEnable || tick)
				tickCount <= '0;
			else
				tickCount <= tickCount + 1'b1;

			if (applyToggle || startStep)
				tickPending <= 1'b0;
			else if (tick)
				tickPending <= 1'b1;  // At most one held

			if (jobValid && jobReady)
				jobIssued <= 1'b1;
			else if (rowFinished)
				jobIssued <= 1'b0;

			case (state)
				OffIdle, OnIdle:
				begin
					if (applyToggle)
					begin
						gameOn <= !gameOn;
						state <= Sweeping;
					end
					else if (startStep)
					begin
						slot <= '0;
						state <= Stepping;
					end
				end
				Sweeping:
					if (sweepDone)
						state <= gameOn ? OnIdle : OffIdle;
				Stepping:
					state <= PaintDraw;  // Tracker rows valid next cycle
				PaintDraw:
					if (rowFinished)
						state <= PaintErase;
				PaintErase:
				begin
					if (rowFinished)
					begin
						if (slot == laneIndex'(LaneCount - 1))
							state <= OnIdle;
						else
						begin
							slot <= slot + 1'b1;
							state <= Stepping;
						end
					end
				end
				default:
					state <= OffIdle;
			endcase
		end
	end

	// Both pixel sources must be quiet whenever the sequencer rests
	idleQuiet: assert property (@(posedge CLOCK_50) disable iff (reset)
		isIdle |-> !pixelValid && !sweepValid && !paintValid)
		else $error("Pixel source active while the sequencer is idle");

endmodule

// ==== source/tileDisplayTop.sv ====
module tileDisplayTop (
	input  logic                  CLOCK_50,
	input  logic                  reset,
	input  logic                  gameKey,
	output displayPkg::pixelWrite pixelOut,
	output logic                  pixelValid,
	input  logic                  pixelReady
);
	import displayPkg::*;
	import tilePkg::*;

	logic      sweepStart;
	logic      sweepBackground;
	pixelWrite sweepPixel;
	logic      sweepValid;
	logic      sweepReady;
	logic      sweepDone;
	logic      tileReset;
	logic      stepSlot;
	laneIndex  stepIndex;
	rowJob     drawJob;
	logic      drawValid;
	rowJob     eraseJob;
	logic      eraseValid;
	rowJob     job;
	logic      jobValid;
	logic      jobReady;
	pixelWrite paintPixel;
	logic      paintValid;
	logic      paintReady;
	logic      paintDone;

	tileSequencer i_tileSequencer (.*);

	// Full-screen clear or background
	screenSweeper i_screenSweeper (
		.CLOCK_50, .reset, .sweepStart, .sweepBackground,
		.sweepPixel, .sweepValid, .sweepReady, .sweepDone
	);

	tileTracker i_tileTracker (
		.CLOCK_50, .reset, .tileReset, .stepSlot, .stepIndex,
		.drawJob, .drawValid, .eraseJob, .eraseValid
	);

	rowPainter i_rowPainter (
		.CLOCK_50, .reset, .job, .jobValid, .jobReady,
		.paintPixel, .paintValid, .paintReady, .paintDone
	);

endmodule

// ==== include/tileDisplayCases.svh ====
`ifndef TILE_DISPLAY_CASES_SVH
`define TILE_DISPLAY_CASES_SVH

// Included after the displayPkg and tilePkg imports
typedef enum logic [1:0] {ActPress, ActTicks, ActSweep} caseAction;

typedef struct packed {
	xCoord x;
	yCoord y;
	colour want;
} probe;

localparam int ProbeCount = 4;
localparam int CaseCount = 10;

typedef struct packed {
	logic [8*14-1:0]             name;
	caseAction                   action;
	logic [7:0]                  count;      // Ticks to wait for ActTicks
	logic                        hasProbes;
	probe [ProbeCount-1:0]       probes;
} testCase;

localparam probe NoProbe = '{8'd0, 7'd0, ColourBlack};

// Tick counts add up, so "tick 60" is 60 steps after the sweep
localparam testCase Cases [CaseCount] = '{
	'{"quiet reset", ActTicks, 8'd2, 1'b0, '{NoProbe, NoProbe, NoProbe, NoProbe}},
	'{"press on", ActPress, 8'd0, 1'b0, '{NoProbe, NoProbe, NoProbe, NoProbe}},
	'{"background", ActSweep, 8'd0, 1'b1, '{'{8'd40, 7'd60, ColourGreen},
		'{8'd120, 7'd119, ColourGreen}, '{8'd0, 7'd0, ColourWhite}, '{8'd159, 7'd119, ColourWhite}}},
	'{"tick 1", ActTicks, 8'd1, 1'b1, '{'{8'd4, 7'd0, ColourBlack},
		'{8'd39, 7'd0, ColourBlack}, '{8'd3, 7'd0, ColourWhite}, '{8'd121, 7'd1, ColourWhite}}},
	'{"tick 20", ActTicks, 8'd19, 1'b1, '{'{8'd43, 7'd19, ColourBlack},
		'{8'd78, 7'd0, ColourBlack}, '{8'd82, 7'd20, ColourWhite}, '{8'd156, 7'd10, ColourBlack}}},
	'{"tick 60", ActTicks, 8'd40, 1'b1, '{'{8'd4, 7'd39, ColourWhite},
		'{8'd4, 7'd40, ColourBlack}, '{8'd43, 7'd59, ColourBlack}, '{8'd82, 7'd60, ColourWhite}}},
	'{"tick 130", ActTicks, 8'd70, 1'b1, '{'{8'd4, 7'd110, ColourBlack},
		'{8'd156, 7'd119, ColourBlack}, '{8'd121, 7'd109, ColourWhite}, '{8'd40, 7'd115, ColourGreen}}},
	'{"lane change", ActTicks, 8'd13, 1'b1, '{'{8'd43, 7'd2, ColourBlack},
		'{8'd43, 7'd3, ColourWhite}, '{8'd4, 7'd119, ColourWhite}, '{8'd121, 7'd0, ColourBlack}}},
	'{"press off", ActPress, 8'd0, 1'b0, '{NoProbe, NoProbe, NoProbe, NoProbe}},
	'{"black screen", ActSweep, 8'd0, 1'b1, '{'{8'd0, 7'd0, ColourBlack},
		'{8'd40, 7'd50, ColourBlack}, '{8'd159, 7'd119, ColourBlack}, '{8'd82, 7'd1, ColourBlack}}}
};

`endif

// ==== verif/tileDisplayTb.sv ====
module tileDisplayTb;
	import displayPkg::*;
	import tilePkg::*;
	`include "tileDisplayCases.svh"

	logic      CLOCK_50;
	logic      reset;
	logic      gameKey;
	pixelWrite pixelOut;
	logic      pixelValid;
	logic      pixelReady;

	integer    seed = 32'hd4a1_86c4;
	colour     shadow [ScreenWidth][ScreenHeight];  // Mirror of the external frame buffer
	int        transferCount;
	int        portErrors;
	int        cycleCount;
	logic      stalled;
	pixelWrite heldPixel;
	bit        gameOnModel;
	int        tickModel;   // Ticks since the tiles were reset

	tileDisplayTop i_tileDisplayTop (.*);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	// Ready is high about three cycles in four
	initial
	begin
		pixelReady = 1'b0;
		forever
		begin
			@(posedge CLOCK_50);
			pixelReady <= ($random(seed) & 3) != 0;
		end
	end

	// Background, then the black tile rows that should be visible after some ticks
	function automatic colour expectedColour(int x, int y, bit on, int ticks);
		int    depth;
		int    top;
		int    lane;
		colour c;
		if (!on)
			return ColourBlack;
		c = (x == BorderX0 || x == BorderX1 || x == BorderX2) ? ColourGreen : ColourWhite;
		depth = ticks % DepthEnd;
		top = (depth > TileHeight) ? depth - TileHeight : 0;
		for (int t = 0; t < LaneCount; t++)
		begin
			lane = (t + ticks / DepthEnd) % LaneCount;
			if (x >= LaneX[lane] && x < LaneX[lane] + TileWidth && y >= top && y < depth
				&& y < ScreenHeight)
				c = ColourBlack;
		end
		return c;
	endfunction

	// Transfers caused by tick number n, counted from 1
	function automatic int rowsPerTick(int n);
		int depth;
		int rows;
		depth = (n - 1) % DepthEnd;
		rows = int'(depth < ScreenHeight) + int'(depth >= TileHeight);
		return rows * LaneCount * TileWidth;
	endfunction

	function automatic int timeoutCycles();
		int total;
		total = 100;
		for (int i = 0; i < CaseCount; i++)
		begin
			case (Cases[i].action)
				ActPress: total += 10;
				ActTicks: total += Cases[i].count * TickCycles;
				default:  total += ScreenWidth * ScreenHeight + 2 * TickCycles;
			endcase
		end
		return 2 * total;  // Room for back-pressure
	endfunction

	task automatic pressKey();
		@(posedge CLOCK_50);
		gameKey <= 1'b0;
		repeat (3) @(posedge CLOCK_50);
		gameKey <= 1'b1;
	endtask

	task automatic waitTransfers(input int target);
		while (transferCount < target)
			@(negedge CLOCK_50);
	endtask

	task automatic compareFrame(input logic [8*14-1:0] name, inout int errs);
		int    bad;
		int    firstX;
		int    firstY;
		colour want;
		bad = 0;
		firstX = 0;
		firstY = 0;
		for (int x = 0; x < ScreenWidth; x++)
			for (int y = 0; y < ScreenHeight; y++)
			begin
				want = expectedColour(x, y, gameOnModel, tickModel);
				if (shadow[x][y] !== want)
				begin
					if (bad == 0)
					begin
						firstX = x;
						firstY = y;
					end
					bad++;
				end
			end
		assert (bad == 0)
		else
		begin
			$display("Error: %s frame mismatches expected 0, actual %0d (first at %0d,%0d)",
				name, bad, firstX, firstY);
			errs++;
		end
	endtask

	// Shadow writes and stall check, sampled on the rising edge
	always @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			stalled <= 1'b0;
			transferCount <= 0;
			portErrors <= 0;
		end
		else
		begin
			assert (!stalled || (pixelValid && pixelOut == heldPixel))
			else
			begin
				$display("Pixel port dropped or changed its pixel while stalled, cycle %0d",
					cycleCount);
				portErrors <= portErrors + 1;
			end
			if (pixelValid && pixelReady)
			begin
				if (pixelOut.x < ScreenWidth && pixelOut.y < ScreenHeight)
					shadow[pixelOut.x][pixelOut.y] <= pixelOut.rgb;
				else
				begin
					$display("Pixel written outside the screen at %0d,%0d", pixelOut.x, pixelOut.y);
					portErrors <= portErrors + 1;
				end
				transferCount <= transferCount + 1;
			end
			stalled <= pixelValid && !pixelReady;
			heldPixel <= pixelOut;
		end
	end

	initial
	begin
		int limit;
		limit = timeoutCycles();
		cycleCount = 0;
		while (cycleCount < limit)
		begin
			@(posedge CLOCK_50);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the DUT stopped making progress", limit);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		testCase tc;
		int      mark;
		int      target;
		int      pressMark;
		int      caseErrors;
		int      passCount;
		int      failCount;
		colour   actual;
		reset = 1'b1;
		gameKey = 1'b1;
		gameOnModel = 1'b0;
		tickModel = 0;
		pressMark = 0;
		passCount = 0;
		failCount = 0;
		repeat (4) @(posedge CLOCK_50);
		reset <= 1'b0;
		for (int i = 0; i < CaseCount; i++)
		begin
			tc = Cases[i];
			caseErrors = 0;
			@(negedge CLOCK_50);
			mark = transferCount;
			case (tc.action)
				ActPress:
				begin
					pressMark = transferCount;
					pressKey();
					gameOnModel = !gameOnModel;
					tickModel = 0;
				end
				ActTicks:
				begin
					if (!gameOnModel)
					begin
						repeat (tc.count * TickCycles) @(negedge CLOCK_50);
						assert (transferCount == mark)
						else
						begin
							$display("Error: %s transfers expected 0, actual %0d", tc.name,
								transferCount - mark);
							caseErrors++;
						end
					end
					else
					begin
						target = mark;
						for (int n = 0; n < tc.count; n++)
						begin
							tickModel++;
							target += rowsPerTick(tickModel);
						end
						waitTransfers(target);
					end
				end
				default:
				begin
					waitTransfers(pressMark + ScreenWidth * ScreenHeight);
					if (!gameOnModel)
					begin
						repeat (2 * TickCycles) @(negedge CLOCK_50);  // Nothing may follow
						assert (transferCount == pressMark + ScreenWidth * ScreenHeight)
						else
						begin
							$display("Error: %s transfers expected %0d, actual %0d", tc.name,
								ScreenWidth * ScreenHeight, transferCount - pressMark);
							caseErrors++;
						end
					end
				end
			endcase
			if (tc.hasProbes)
			begin
				for (int p = 0; p < ProbeCount; p++)
				begin
					actual = shadow[tc.probes[p].x][tc.probes[p].y];
					assert (actual === tc.probes[p].want)
					else
					begin
						$display("Error: %s probe (%0d,%0d) expected %0d, actual %0d", tc.name,
							tc.probes[p].x, tc.probes[p].y, tc.probes[p].want, actual);
						caseErrors++;
					end
				end
				compareFrame(tc.name, caseErrors);
			end
			if (caseErrors == 0)
				passCount++;
			else
				failCount++;
			$display("%s %s with %0d errors", (caseErrors == 0) ? "PASS" : "FAIL", tc.name,
				caseErrors);
		end
		$display("Tests passed %0d, failed %0d, port errors %0d", passCount, failCount,
			portErrors);
		if (failCount == 0 && portErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
source/displayPkg.sv
source/tilePkg.sv
source/rowPainter.sv
source/screenSweeper.sv
source/tileTracker.sv
source/tileSequencer.sv
source/tileDisplayTop.sv
verif/tileDisplayTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the tile display testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tileDisplayTb \
	-f compile.f \
	-o tileDisplaySim

./obj_dir/tileDisplaySim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi
